// File: bench/daFirVectors.txt
# test name | write addr data | read addr expected | sample value accept(1/0)
# expect result | wait cycles (decimal); all other numbers are hex
test registers
read 0 0000
read 1 0000
write 1 FFFF
read 1 000F
write 0 0003
read 0 0003
read 2 0000
read 3 0000
write 0 0000
write 1 0000
read 0 0000
test enableGating
sample 1234 0
wait 25
test impulse
write 0 0001
sample 0001 1
sample 0000 1
expect FFF9
sample 0000 1
expect 0013
sample 0000 1
expect FFD3
sample 0000 1
expect 00A0
sample 0000 1
expect 01A4
sample 0000 1
expect 012C
sample 0000 1
expect FFA8
expect 0021
test arbitrary
sample 0064 1
sample FF38 1
sample 7FFF 0
expect FD44
sample 0032 1
expect 0CE4
sample FFFD 1
expect DE36
expect 6573
test outputStage
write 1 0004
sample 0003 1
expect 01E0
sample 0008 1
expect F4CE
write 1 0000
write 0 0003
sample 0000 1
expect 8000
sample 0000 1
expect 7FFF
write 0 0001
sample 7FFF 1
expect 5B77
sample 0000 1
expect 980B

// File: daFirTop.f
+incdir+rtl
rtl/daFirPkg.sv
rtl/daLut.sv
rtl/daLutUnit.sv
rtl/tapDelayLine.sv
rtl/daAccumulator.sv
rtl/firConfig.sv
rtl/daFirTop.sv
bench/daFirTb.sv

// File: Bender.yml
package:
  name: dafir

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/daFirPkg.sv
      - rtl/daLut.sv
      - rtl/daLutUnit.sv
      - rtl/tapDelayLine.sv
      - rtl/daAccumulator.sv
      - rtl/firConfig.sv
      - rtl/daFirTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/daFirTb.sv

// File: bench/daFirTb.sv
`timescale 1ns/1ps
`include "daFir_consts.svh"

module daFirTb;
    import daFirPkg::*;

    localparam int ResultLatency = `DA_SAMPLE_BITS + `DA_LUT_LATENCY + 1;

    logic    clk = 1'b0;
    logic    reset;
    logic    sampleValid;
    sampleT  sampleIn;
    logic    cfgWrite;
    cfgAddrT cfgAddr;
    cfgDataT cfgWriteData;
    cfgDataT cfgReadData;
    logic    busy;
    resultT  result;
    logic    resultValid;

    int    cycle = 0;
    int    cycleLimit = 1000000;
    int    dueQ [$];      // Cycles at which accepted samples must produce a result.
    int    testErrors;
    int    errorTotal;
    int    passCount;
    int    failCount;
    string testName;

    daFirTop UUT (
        .clk          (clk),
        .reset        (reset),
        .sampleValid  (sampleValid),
        .sampleIn     (sampleIn),
        .cfgWrite     (cfgWrite),
        .cfgAddr      (cfgAddr),
        .cfgWriteData (cfgWriteData),
        .cfgReadData  (cfgReadData),
        .busy         (busy),
        .result       (result),
        .resultValid  (resultValid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycleLimit) begin
            $display("Timeout after %0d cycles, the vectors did not complete.", cycle);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ******************************************************************
    // Checks
    // ******************************************************************

    task automatic noteError(input string msg);
        $display("%s", msg);
        testErrors++;
        errorTotal++;
    endtask

    task automatic checkResult(input resultT got, input resultT exp);
        if (got !== exp) begin
            noteError($sformatf("FAILED result got %h expected %h", got, exp));
        end
    endtask

    task automatic checkReg(input cfgAddrT addr, input cfgDataT got, input cfgDataT exp);
        if (got !== exp) begin
            noteError($sformatf("FAILED cfgReadData (address %0d) got %h expected %h",
                                addr, got, exp));
        end
    endtask

    // One clock, then inputs may change. Stray result strobes are caught here.
    task automatic stepCycle();
        bit pending;
        @(posedge clk);
        #1;
        if (resultValid === 1'b1) begin
            pending = 1'b0;
            foreach (dueQ[i]) begin
                if (dueQ[i] == cycle) begin
                    pending = 1'b1;
                end
            end
            if (!pending) begin
                noteError("resultValid pulsed while no result was pending.");
            end
        end
    endtask

    // ******************************************************************
    // Vector commands
    // ******************************************************************

    task automatic applyWrite(input cfgAddrT addr, input cfgDataT data);
        cfgWrite     = 1'b1;
        cfgAddr      = addr;
        cfgWriteData = data;
        stepCycle();
        cfgWrite = 1'b0;
    endtask

    task automatic checkRead(input cfgAddrT addr, input cfgDataT exp);
        cfgAddr = addr;
        stepCycle();
        checkReg(addr, cfgReadData, exp);
    endtask

    task automatic applySample(input sampleT value, input bit accept);
        logic wasBusy;
        if (accept) begin
            while (busy) begin
                stepCycle();   // Strobe lands on the cycle busy falls.
            end
        end
        wasBusy     = busy;
        sampleValid = 1'b1;
        sampleIn    = value;
        stepCycle();
        sampleValid = 1'b0;
        if (accept && busy !== 1'b1) begin
            noteError("A sample sent to an idle, enabled filter was not accepted.");
        end else if (accept) begin
            dueQ.push_back(cycle + ResultLatency);
        end else if (!wasBusy && busy !== 1'b0) begin
            noteError("A sample strobe that should be ignored started the filter.");
        end
    endtask

    task automatic awaitResult(input resultT exp);
        int due;
        if (dueQ.size() == 0) begin
            noteError("A result was expected but no sample had been accepted for it.");
        end else begin
            due = dueQ[0];
            while (cycle < due) begin
                stepCycle();
            end
            if (cycle > due) begin
                noteError("The result was due before the vectors asked for it.");
            end else if (resultValid !== 1'b1) begin
                noteError($sformatf("resultValid did not arrive %0d cycles after acceptance.",
                                    ResultLatency));
            end else begin
                checkResult(result, exp);
            end
            void'(dueQ.pop_front());
        end
    endtask

    task automatic finishTest();
        if (testName != "") begin
            if (testErrors == 0) begin
                passCount++;
                $display("Test %s passed.", testName);
            end else begin
                failCount++;
                $display("Test %s failed with %0d errors.", testName, testErrors);
            end
        end
        testErrors = 0;
    endtask

    // Run length from the vectors: one result latency per sample plus the waits.
    task automatic scanLimits(input int fd);
        string line;
        string cmd;
        int    arg;
        int    samples;
        int    waits;
        samples = 0;
        waits   = 0;
        while ($fgets(line, fd)) begin
            if ($sscanf(line, "%s %d", cmd, arg) >= 1) begin
                if (cmd == "sample") begin
                    samples++;
                end else if (cmd == "wait") begin
                    waits += arg;
                end
            end
        end
        cycleLimit = samples * ResultLatency + waits + 200;
    endtask

    initial begin
        int    fd;
        int    a;
        int    b;
        string line;
        string cmd;
        reset        = 1'b1;
        sampleValid  = 1'b0;
        sampleIn     = '0;
        cfgWrite     = 1'b0;
        cfgAddr      = '0;
        cfgWriteData = '0;
        testErrors   = 0;
        errorTotal   = 0;
        passCount    = 0;
        failCount    = 0;
        testName     = "";
        fd = $fopen("bench/daFirVectors.txt", "r");
        if (fd == 0) begin
            noteError("Could not open bench/daFirVectors.txt.");
        end else begin
            scanLimits(fd);
            $fclose(fd);
            fd = $fopen("bench/daFirVectors.txt", "r");
            repeat (8) stepCycle();
            reset = 1'b0;
            while ($fgets(line, fd)) begin
                if ($sscanf(line, "%s", cmd) < 1 || cmd[0] == "#") begin
                    continue;
                end
                if (cmd == "test") begin
                    finishTest();
                    void'($sscanf(line, "%s %s", cmd, testName));
                end else if (cmd == "write") begin
                    void'($sscanf(line, "%s %h %h", cmd, a, b));
                    applyWrite(cfgAddrT'(a), cfgDataT'(b));
                end else if (cmd == "read") begin
                    void'($sscanf(line, "%s %h %h", cmd, a, b));
                    checkRead(cfgAddrT'(a), cfgDataT'(b));
                end else if (cmd == "sample") begin
                    void'($sscanf(line, "%s %h %d", cmd, a, b));
                    applySample(sampleT'(a), b != 0);
                end else if (cmd == "expect") begin
                    void'($sscanf(line, "%s %h", cmd, a));
                    awaitResult(resultT'(a));
                end else if (cmd == "wait") begin
                    void'($sscanf(line, "%s %d", cmd, a));
                    repeat (a) stepCycle();
                end else begin
                    noteError($sformatf("Unknown vector command %s.", cmd));
                end
            end
            $fclose(fd);
            if (dueQ.size() != 0) begin
                noteError("Accepted samples were left without a checked result.");
            end
            finishTest();
        end
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (errorTotal == 0 && failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: rtl/daFirTop.sv
`timescale 1ns/1ps
`include "daFir_consts.svh"

module daFirTop (
    input  logic                clk,
    input  logic                reset,
    input  logic                sampleValid,
    input  daFirPkg::sampleT    sampleIn,
    input  logic                cfgWrite,
    input  daFirPkg::cfgAddrT   cfgAddr,
    input  daFirPkg::cfgDataT   cfgWriteData,
    output daFirPkg::cfgDataT   cfgReadData,
    output logic                busy,
    output daFirPkg::resultT    result,
    output logic                resultValid
);
    import daFirPkg::*;

    logic                enable;
    logic                saturate;
    shiftT               shift;
    logic [`DA_TAPS-1:0] bitPlane;
    logic                planeValid;
    logic                planeFirst;
    logic                planeLast;
    accT                 partialSum;

    firConfig config_ (
        .clk          (clk),
        .reset        (reset),
        .cfgWrite     (cfgWrite),
        .cfgAddr      (cfgAddr),
        .cfgWriteData (cfgWriteData),
        .cfgReadData  (cfgReadData),
        .enable       (enable),
        .saturate     (saturate),
        .shift        (shift)
    );

    tapDelayLine delayLine (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .sampleValid (sampleValid),
        .sampleIn    (sampleIn),
        .busy        (busy),
        .bitPlane    (bitPlane),
        .planeValid  (planeValid),
        .planeFirst  (planeFirst),
        .planeLast   (planeLast)
    );

    daLutUnit lutUnit (
        .clk        (clk),
        .bitPlane   (bitPlane),
        .partialSum (partialSum)
    );

    // Markers go in undelayed. The accumulator lines them up with partialSum.
    daAccumulator accum (
        .clk         (clk),
        .reset       (reset),
        .partialSum  (partialSum),
        .planeValid  (planeValid),
        .planeFirst  (planeFirst),
        .planeLast   (planeLast),
        .saturate    (saturate),
        .shift       (shift),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

// File: rtl/firConfig.sv
`timescale 1ns/1ps
`include "daFir_consts.svh"

module firConfig (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfgWrite,
    input  daFirPkg::cfgAddrT   cfgAddr,
    input  daFirPkg::cfgDataT   cfgWriteData,
    output daFirPkg::cfgDataT   cfgReadData,
    output logic                enable,
    output logic                saturate,
    output daFirPkg::shiftT     shift
);
    import daFirPkg::*;

    ctrlRegT ctrlReg;
    shiftT   shiftReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg  <= '0;
            shiftReg <= '0;
        end else if (cfgWrite) begin
            case (cfgAddr)
                `DA_ADDR_CTRL:  ctrlReg  <= ctrlRegT'(cfgWriteData[$bits(ctrlRegT)-1:0]);
                `DA_ADDR_SHIFT: shiftReg <= cfgWriteData[$bits(shiftT)-1:0];
                default: ;   // Unused addresses.
            endcase
        end
    end

    // Readback straight from the address.
    always_comb begin
        case (cfgAddr)
            `DA_ADDR_CTRL:  cfgReadData = cfgDataT'(ctrlReg);
            `DA_ADDR_SHIFT: cfgReadData = cfgDataT'(shiftReg);
            default:        cfgReadData = '0;
        endcase
    end

    assign enable   = ctrlReg.enable;
    assign saturate = ctrlReg.saturate;
    assign shift    = shiftReg;

endmodule

// File: rtl/daAccumulator.sv
`timescale 1ns/1ps
`include "daFir_consts.svh"

module daAccumulator (
    input  logic               clk,
    input  logic               reset,
    input  daFirPkg::accT      partialSum,
    input  logic               planeValid,
    input  logic               planeFirst,
    input  logic               planeLast,
    input  logic               saturate,
    input  daFirPkg::shiftT    shift,
    output daFirPkg::resultT   result,
    output logic               resultValid
);
    import daFirPkg::*;

    localparam int Lat     = `DA_LUT_LATENCY;
    localparam int IdxBits = $clog2(`DA_SAMPLE_BITS);
    localparam coefT [`DA_TAPS-1:0] Coefs = `DA_COEFS;
    localparam accT ResMax = (accT'(1) <<< ($bits(resultT) - 1)) - 1;
    localparam accT ResMin = -(accT'(1) <<< ($bits(resultT) - 1));

    function automatic accT coefTotal();
        accT s;
        s = '0;
        for (int k = 0; k < `DA_TAPS; k++) begin
            s = s + Coefs[k];
        end
        return s;
    endfunction

    localparam accT CoefSum = coefTotal();

    logic [Lat-1:0]     validPipe;
    logic [Lat-1:0]     firstPipe;
    logic [Lat-1:0]     lastPipe;
    logic               dValid;
    logic               dFirst;
    logic               dLast;
    logic [IdxBits-1:0] bitIdx;
    logic [IdxBits-1:0] curIdx;
    accT                acc;
    accT                weighted;
    accT                total;
    accT                half;
    accT                rounded;
    accT                shifted;

    // ********************************************************************
    // Marker delay, matched to the LUT unit
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
            firstPipe <= '0;
            lastPipe  <= '0;
        end else begin
            validPipe[0] <= planeValid;
            firstPipe[0] <= planeFirst;
            lastPipe[0]  <= planeLast;
            for (int i = 1; i < Lat; i++) begin
                validPipe[i] <= validPipe[i - 1];
                firstPipe[i] <= firstPipe[i - 1];
                lastPipe[i]  <= lastPipe[i - 1];
            end
        end
    end

    assign dValid = validPipe[Lat-1];
    assign dFirst = firstPipe[Lat-1];
    assign dLast  = lastPipe[Lat-1];

    // ********************************************************************
    // Shift-accumulate and output stage
    // ********************************************************************

    assign curIdx   = dFirst ? '0 : bitIdx;
    assign weighted = partialSum <<< curIdx;
    // Sign plane has weight -2^15.
    assign total    = (dFirst ? -CoefSum : acc) + (dLast ? -weighted : weighted);
    assign half     = total >>> 1;   // Total is always even here.
    assign rounded  = (shift == '0) ? half : half + (accT'(1) <<< (shift - 1'b1));
    assign shifted  = rounded >>> shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            bitIdx      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= dValid && dLast;
            if (dValid) begin
                bitIdx <= curIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dValid) begin
            acc <= total;
        end
        if (dValid && dLast) begin
            if (!saturate) begin
                result <= resultT'(shifted);   // Wrap to the low bits.
            end else if (shifted > ResMax) begin
                result <= resultT'(ResMax);
            end else if (shifted < ResMin) begin
                result <= resultT'(ResMin);
            end else begin
                result <= resultT'(shifted);
            end
        end
    end

endmodule

// File: rtl/tapDelayLine.sv
`timescale 1ns/1ps
`include "daFir_consts.svh"

module tapDelayLine (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic                 sampleValid,
    input  daFirPkg::sampleT     sampleIn,
    output logic                 busy,
    output logic [`DA_TAPS-1:0]  bitPlane,
    output logic                 planeValid,
    output logic                 planeFirst,
    output logic                 planeLast
);
    import daFirPkg::*;

    localparam int CntBits = $clog2(`DA_SAMPLE_BITS);
    localparam logic [CntBits-1:0] LastBit = CntBits'(`DA_SAMPLE_BITS - 1);

    sampleT             taps [`DA_TAPS];
    logic [CntBits-1:0] bitCnt;
    logic               accept;

    assign accept = sampleValid && enable && !busy;

    // Filter history starts from silence.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `DA_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (accept) begin
            taps[0] <= sampleIn;   // Newest sample at tap 0.
            for (int k = 1; k < `DA_TAPS; k++) begin
                taps[k] <= taps[k - 1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            bitCnt     <= '0;
            planeValid <= 1'b0;
            planeFirst <= 1'b0;
            planeLast  <= 1'b0;
        end else begin
            planeValid <= busy;
            planeFirst <= busy && (bitCnt == '0);
            planeLast  <= busy && (bitCnt == LastBit);
            if (accept) begin
                busy   <= 1'b1;
                bitCnt <= '0;
            end else if (busy) begin
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == LastBit) begin
                    busy <= 1'b0;   // Sixteen planes sent.
                end
            end
        end
    end

    // One bit of every tap, LSB first.
    always_ff @(posedge clk) begin
        if (busy) begin
            for (int k = 0; k < `DA_TAPS; k++) begin
                bitPlane[k] <= taps[k][bitCnt];
            end
        end
    end

endmodule

// File: rtl/daLutUnit.sv
`timescale 1ns/1ps
`include "daFir_consts.svh"

module daLutUnit (
    input  logic                 clk,
    input  logic [`DA_TAPS-1:0]  bitPlane,
    output daFirPkg::accT        partialSum
);
    import daFirPkg::*;

    localparam int NParts  = (`DA_TAPS + `DA_LUT_SIZE - 1) / `DA_LUT_SIZE;
    localparam int NLayers = $clog2(NParts);
    localparam coefT [`DA_TAPS-1:0] Coefs = `DA_COEFS;

    // Nodes in one layer of the tree. Layer 0 is the partition registers.
    function automatic int layerNodes(int layer);
        int n;
        n = NParts;
        for (int i = 0; i < layer; i++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    // First node of a layer in the flat node array.
    function automatic int layerBase(int layer);
        int base;
        base = 0;
        for (int i = 0; i < layer; i++) begin
            base += layerNodes(i);
        end
        return base;
    endfunction

    localparam int NNodes = layerBase(NLayers + 1);

    accT lutOut [NParts];
    accT node   [NNodes];

    // ********************************************************************
    // Table partitions
    // ********************************************************************

    for (genvar p = 0; p < NParts; p++) begin : partGen
        localparam int Lo    = p * `DA_LUT_SIZE;
        localparam int Width = (`DA_TAPS - Lo < `DA_LUT_SIZE) ? (`DA_TAPS - Lo) : `DA_LUT_SIZE;
        localparam coefT [Width-1:0] Slice = Coefs[Lo +: Width];

        daLut #(
            .size  (Width),
            .coefs (Slice)
        ) lut (
            .sel     (bitPlane[Lo +: Width]),
            .partial (lutOut[p])
        );

        always_ff @(posedge clk) begin
            node[p] <= lutOut[p];
        end
    end

    // ********************************************************************
    // Adder tree
    // ********************************************************************

    for (genvar l = 1; l <= NLayers; l++) begin : layerGen
        localparam int Prev    = layerBase(l - 1);
        localparam int Cur     = layerBase(l);
        localparam int PrevCnt = layerNodes(l - 1);

        for (genvar i = 0; i < layerNodes(l); i++) begin : nodeGen
            if (2 * i + 1 < PrevCnt) begin : addGen
                always_ff @(posedge clk) begin
                    node[Cur + i] <= node[Prev + 2 * i] + node[Prev + 2 * i + 1];
                end
            end else begin : passGen
                always_ff @(posedge clk) begin
                    node[Cur + i] <= node[Prev + 2 * i];   // Odd leftover waits a stage.
                end
            end
        end
    end

    assign partialSum = node[layerBase(NLayers)];

endmodule

// File: rtl/daLut.sv
`timescale 1ns/1ps

module daLut #(
    parameter int                          size  = 4,
    parameter daFirPkg::coefT [size-1:0]   coefs = '0
) (
    input  logic [size-1:0]  sel,
    output daFirPkg::accT    partial
);
    import daFirPkg::*;

    accT lutRom [2**size];

    // Offset-binary entry: +c for a set bit, -c for a clear one.
    function automatic accT entryValue(int index);
        accT acc;
        acc = '0;
        for (int j = 0; j < size; j++) begin
            if (index[j]) begin
                acc = acc + coefs[j];
            end else begin
                acc = acc - coefs[j];
            end
        end
        return acc;
    endfunction

    for (genvar i = 0; i < 2**size; i++) begin : romGen
        localparam accT Entry = entryValue(i);
        assign lutRom[i] = Entry;
    end

    assign partial = lutRom[sel];

endmodule

// File: rtl/daFirPkg.sv
`include "daFir_consts.svh"

package daFirPkg;

    typedef logic signed [`DA_SAMPLE_BITS-1:0] sampleT;
    typedef logic signed [`DA_COEF_BITS-1:0]   coefT;
    typedef logic signed [`DA_ACC_BITS-1:0]    accT;

    // Output keeps the sample width.
    typedef logic signed [`DA_SAMPLE_BITS-1:0] resultT;

    typedef logic [$clog2(`DA_SAMPLE_BITS)-1:0] shiftT;

    // Register port.
    typedef logic [1:0]  cfgAddrT;
    typedef logic [15:0] cfgDataT;

    // Control register layout, bit 0 is enable.
    typedef struct packed {
        logic saturate;
        logic enable;
    } ctrlRegT;

endpackage

// File: rtl/daFir_consts.svh
`ifndef DAFIR_CONSTS_SVH
`define DAFIR_CONSTS_SVH

// Filter geometry.
`define DA_TAPS         8
`define DA_SAMPLE_BITS  16
`define DA_COEF_BITS    12
`define DA_ACC_BITS     32
`define DA_LUT_SIZE     4

// Coefficients listed c7 down to c0, so tap 0 (newest sample) is the last element.
`define DA_COEFS {12'sd33, -12'sd88, 12'sd300, 12'sd420, 12'sd160, -12'sd45, 12'sd19, -12'sd7}

// Partition registers plus one stage per adder layer.
`define DA_LUT_LATENCY (1 + $clog2((`DA_TAPS + `DA_LUT_SIZE - 1) / `DA_LUT_SIZE))

// Register map.
`define DA_ADDR_CTRL    2'd0
`define DA_ADDR_SHIFT   2'd1

`endif
